//--- div_pkg.sv
package div_pkg;

   localparam int DATA_W = 32;
   localparam int CMD_W  = 2 + 2 * DATA_W;  // Opcode, dividend, divisor.

   typedef enum logic [1:0] {
      DIVU = 2'd0,
      DIV  = 2'd1,
      REMU = 2'd2,
      REM  = 2'd3
   } div_op_t;

   typedef enum logic [1:0] {
      IDLE = 2'd0,
      LOAD = 2'd1,
      ITER = 2'd2,
      DONE = 2'd3
   } core_state_t;

   // Register map, byte offsets.
   localparam logic [4:0] REG_DIVIDEND = 5'h00;
   localparam logic [4:0] REG_DIVISOR  = 5'h04;
   localparam logic [4:0] REG_CMD      = 5'h08;  // Bits 1:0 opcode.
   localparam logic [4:0] REG_RESULT   = 5'h0C;  // Read pops.
   localparam logic [4:0] REG_STATUS   = 5'h10;

endpackage

//--- div_fifo.sv
`timescale 1ns/10ps

module div_fifo import div_pkg::*; #(
   parameter int WIDTH      = DATA_W,
   parameter int FIFO_DEPTH = 4
) (
   input  logic             clk,
   input  logic             resetn,
   input  logic             push,
   input  logic [WIDTH-1:0] push_data,
   input  logic             pop,
   output logic [WIDTH-1:0] pop_data,
   output logic             full,
   output logic             empty
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [WIDTH-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign do_push  = push && !full;
   assign do_pop   = pop && !empty;
   assign pop_data = mem[rd_ptr];  // Head entry.
   assign full     = (count == CNT_W'(FIFO_DEPTH));
   assign empty    = (count == '0);

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (!resetn) push |-> !full)
      else $error("div_fifo: push while full");
   a_no_underflow: assert property (@(posedge clk) disable iff (!resetn) pop |-> !empty)
      else $error("div_fifo: pop while empty");

endmodule

//--- div_axil_regs.sv
`timescale 1ns/10ps

module div_axil_regs import div_pkg::*; (
   input  logic                clk,
   input  logic                resetn,
   input  logic [4:0]          awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  logic [DATA_W-1:0]   wdata,
   input  logic [DATA_W/8-1:0] wstrb,
   input  logic                wvalid,
   output logic                wready,
   output logic [1:0]          bresp,
   output logic                bvalid,
   input  logic                bready,
   input  logic [4:0]          araddr,
   input  logic                arvalid,
   output logic                arready,
   output logic [DATA_W-1:0]   rdata,
   output logic [1:0]          rresp,
   output logic                rvalid,
   input  logic                rready,
   output logic                cmd_push,
   output logic [CMD_W-1:0]    cmd_data,
   input  logic                cmd_full,
   output logic                res_pop,
   input  logic [DATA_W-1:0]   res_q,
   input  logic                res_empty
);

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic [DATA_W-1:0] dividend_q;
   logic [DATA_W-1:0] divisor_q;
   logic              wr_hs;
   logic              rd_hs;
   logic              strb_ok;
   logic              wr_err;
   logic              rd_err;
   logic [DATA_W-1:0] rd_value;
   div_op_t           wr_op;

   // Address and data are taken together, one write in flight.
   assign wr_hs   = awvalid && wvalid && !bvalid;
   assign awready = wr_hs;
   assign wready  = wr_hs;
   assign strb_ok = &wstrb;  // Partial writes unsupported.
   assign wr_op   = div_op_t'(wdata[1:0]);

   assign cmd_push = wr_hs && strb_ok && (awaddr == REG_CMD) && !cmd_full;
   assign cmd_data = {wr_op, dividend_q, divisor_q};

   always_comb begin
      case (awaddr)
         REG_DIVIDEND, REG_DIVISOR: wr_err = !strb_ok;
         REG_CMD:                   wr_err = !strb_ok || cmd_full;  // Job dropped.
         default:                   wr_err = 1'b1;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         dividend_q <= '0;
         divisor_q  <= '0;
      end else if (wr_hs && strb_ok) begin
         if (awaddr == REG_DIVIDEND)
            dividend_q <= wdata;
         if (awaddr == REG_DIVISOR)
            divisor_q <= wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         bvalid <= 1'b0;
         bresp  <= RESP_OKAY;
      end else if (wr_hs) begin
         bvalid <= 1'b1;
         bresp  <= wr_err ? RESP_SLVERR : RESP_OKAY;
      end else if (bready) begin
         bvalid <= 1'b0;
      end
   end

   assign rd_hs   = arvalid && !rvalid;
   assign arready = rd_hs;
   assign res_pop = rd_hs && (araddr == REG_RESULT) && !res_empty;

   always_comb begin
      rd_value = '0;
      rd_err   = 1'b0;
      case (araddr)
         REG_RESULT: begin
            rd_value = res_empty ? '0 : res_q;
            rd_err   = res_empty;
         end
         REG_STATUS: rd_value = {{(DATA_W-2){1'b0}}, cmd_full, !res_empty};
         default:    rd_err = 1'b1;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rd_hs)
         rdata <= rd_value;
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rvalid <= 1'b0;
         rresp  <= RESP_OKAY;
      end else if (rd_hs) begin
         rvalid <= 1'b1;
         rresp  <= rd_err ? RESP_SLVERR : RESP_OKAY;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   a_bvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
      bvalid && !bready |=> bvalid && $stable(bresp));
   a_rvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
      rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

//--- div_seq_core.sv
`timescale 1ns/10ps

module div_seq_core import div_pkg::*; (
   input  logic              clk,
   input  logic              resetn,
   input  logic [CMD_W-1:0]  cmd_q,
   input  logic              cmd_empty,
   output logic              cmd_pop,
   output logic              res_push,
   output logic [DATA_W-1:0] res_data,
   input  logic              res_full
);

   localparam int CNT_W = $clog2(DATA_W);

   core_state_t         state;
   div_op_t             op_q;
   logic [DATA_W-1:0]   dvd_q;
   logic [DATA_W-1:0]   dvs_q;
   logic [2*DATA_W-1:0] rem_q;   // Partial remainder.
   logic [2*DATA_W-1:0] dvs_sh;  // Divisor, shifted right each step.
   logic [2*DATA_W-1:0] diff;
   logic [DATA_W-1:0]   quot_q;
   logic [CNT_W-1:0]    cnt;
   logic                neg_q;
   logic                neg_r;
   logic                is_signed;
   logic [DATA_W-1:0]   abs_dvd;
   logic [DATA_W-1:0]   abs_dvs;
   logic [DATA_W-1:0]   q_out;
   logic [DATA_W-1:0]   r_out;

   assign is_signed = (op_q == DIV) || (op_q == REM);
   assign abs_dvd   = (is_signed && dvd_q[DATA_W-1]) ? -dvd_q : dvd_q;
   assign abs_dvs   = (is_signed && dvs_q[DATA_W-1]) ? -dvs_q : dvs_q;
   assign diff      = rem_q - dvs_sh;  // Trial subtraction.

   assign cmd_pop  = (state == IDLE) && !cmd_empty;
   assign res_push = (state == DONE) && !res_full;

   // Remainder follows the dividend sign.
   assign q_out    = neg_q ? -quot_q : quot_q;
   assign r_out    = neg_r ? -rem_q[DATA_W-1:0] : rem_q[DATA_W-1:0];
   assign res_data = (op_q == REMU || op_q == REM) ? r_out : q_out;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state <= IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (cmd_pop)
                  state <= LOAD;
            end
            LOAD: begin
               cnt   <= CNT_W'(DATA_W - 1);
               state <= (dvs_q == '0) ? DONE : ITER;
            end
            ITER: begin
               cnt <= cnt - 1'b1;
               if (cnt == '0)
                  state <= DONE;
            end
            DONE: begin
               if (res_push)
                  state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      case (state)
         IDLE: begin
            if (cmd_pop) begin
               op_q  <= div_op_t'(cmd_q[CMD_W-1 -: 2]);
               dvd_q <= cmd_q[2*DATA_W-1 -: DATA_W];
               dvs_q <= cmd_q[DATA_W-1:0];
            end
         end
         LOAD: begin
            if (dvs_q == '0) begin
               quot_q <= '1;  // Fixed divide by zero result.
               rem_q  <= {{DATA_W{1'b0}}, dvd_q};
               neg_q  <= 1'b0;
               neg_r  <= 1'b0;
            end else begin
               quot_q <= '0;
               rem_q  <= {{DATA_W{1'b0}}, abs_dvd};
               dvs_sh <= {1'b0, abs_dvs, {(DATA_W-1){1'b0}}};
               neg_q  <= is_signed && (dvd_q[DATA_W-1] ^ dvs_q[DATA_W-1]);
               neg_r  <= is_signed && dvd_q[DATA_W-1];
            end
         end
         ITER: begin
            if (!diff[2*DATA_W-1]) begin
               rem_q  <= diff;
               quot_q <= {quot_q[DATA_W-2:0], 1'b1};
            end else begin
               quot_q <= {quot_q[DATA_W-2:0], 1'b0};
            end
            dvs_sh <= dvs_sh >> 1;
         end
         default: ;
      endcase
   end

   // Final magnitude remainder lies below the divisor magnitude.
   a_rem_below_divisor: assert property (@(posedge clk) disable iff (!resetn)
      (state == DONE) && (dvs_q != '0) |-> (rem_q < {{DATA_W{1'b0}}, abs_dvs}));

endmodule

//--- div_unit_top.sv
`timescale 1ns/10ps

module div_unit_top import div_pkg::*; #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                clk,
   input  logic                resetn,
   input  logic [4:0]          awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  logic [DATA_W-1:0]   wdata,
   input  logic [DATA_W/8-1:0] wstrb,
   input  logic                wvalid,
   output logic                wready,
   output logic [1:0]          bresp,
   output logic                bvalid,
   input  logic                bready,
   input  logic [4:0]          araddr,
   input  logic                arvalid,
   output logic                arready,
   output logic [DATA_W-1:0]   rdata,
   output logic [1:0]          rresp,
   output logic                rvalid,
   input  logic                rready
);

   logic              cmd_push;
   logic [CMD_W-1:0]  cmd_data;
   logic              cmd_full;
   logic              cmd_pop;
   logic              cmd_empty;
   logic [CMD_W-1:0]  cmd_q;
   logic              res_push;
   logic [DATA_W-1:0] res_data;
   logic              res_full;
   logic              res_pop;
   logic              res_empty;
   logic [DATA_W-1:0] res_q;

   div_axil_regs u_regs (
      .clk, .resetn,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .cmd_push, .cmd_data, .cmd_full,
      .res_pop, .res_q, .res_empty
   );

   div_fifo #(.WIDTH(CMD_W), .FIFO_DEPTH(FIFO_DEPTH)) u_cmd_fifo (
      .clk, .resetn,
      .push(cmd_push), .push_data(cmd_data), .pop(cmd_pop),
      .pop_data(cmd_q), .full(cmd_full), .empty(cmd_empty)
   );

   div_seq_core u_core (
      .clk, .resetn,
      .cmd_q, .cmd_empty, .cmd_pop,
      .res_push, .res_data, .res_full
   );

   div_fifo #(.WIDTH(DATA_W), .FIFO_DEPTH(FIFO_DEPTH)) u_res_fifo (
      .clk, .resetn,
      .push(res_push), .push_data(res_data), .pop(res_pop),
      .pop_data(res_q), .full(res_full), .empty(res_empty)
   );

endmodule

//--- tb_div_unit.sv
`timescale 1ns/10ps

module tb_div_unit import div_pkg::*; ();

   localparam int NUM_JOBS       = 231;
   localparam int TIMEOUT_CYCLES = NUM_JOBS * 100 + 2000;
   localparam logic [1:0] OKAY   = 2'b00;
   localparam logic [1:0] SLVERR = 2'b10;

   logic              clk;
   logic              resetn;
   logic [4:0]        awaddr;
   logic              awvalid;
   logic              awready;
   logic [DATA_W-1:0] wdata;
   logic [3:0]        wstrb;
   logic              wvalid;
   logic              wready;
   logic [1:0]        bresp;
   logic              bvalid;
   logic              bready;
   logic [4:0]        araddr;
   logic              arvalid;
   logic              arready;
   logic [DATA_W-1:0] rdata;
   logic [1:0]        rresp;
   logic              rvalid;
   logic              rready;

   integer            seed;
   int                errors = 0;
   int                outstanding = 0;
   string             test_name = "reset";
   logic [DATA_W-1:0] exp_q[$];
   logic [DATA_W-1:0] got_q[$];
   string             got_name_q[$];

   div_unit_top #(.FIFO_DEPTH(4)) u_dut (
      .clk, .resetn,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // RISC-V M rules, worked on magnitudes.
   function automatic logic [DATA_W-1:0] ref_div(div_op_t op, logic [DATA_W-1:0] a,
                                                 logic [DATA_W-1:0] b);
      logic              sgn;
      logic [DATA_W-1:0] ma;
      logic [DATA_W-1:0] mb;
      logic [DATA_W-1:0] q;
      logic [DATA_W-1:0] r;
      sgn = (op == DIV) || (op == REM);
      if (b == '0)
         return (op == DIVU || op == DIV) ? '1 : a;
      ma = (sgn && a[DATA_W-1]) ? -a : a;
      mb = (sgn && b[DATA_W-1]) ? -b : b;
      q  = ma / mb;
      r  = ma % mb;
      if (sgn && (a[DATA_W-1] ^ b[DATA_W-1]))
         q = -q;  // Most negative / -1 wraps back to itself.
      if (sgn && a[DATA_W-1])
         r = -r;
      return (op == DIVU || op == DIV) ? q : r;
   endfunction

   // Called 1 ns after a rising edge, returns at the same phase.
   task automatic axil_write(input logic [4:0] addr, input logic [DATA_W-1:0] data,
                             output logic [1:0] resp);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      bready  = 1'b1;
      @(negedge clk);
      while (!awready) @(negedge clk);
      @(posedge clk);
      #1 awvalid = 1'b0;
      wvalid = 1'b0;
      @(negedge clk);
      while (!bvalid) @(negedge clk);
      resp = bresp;
      @(posedge clk);
      #1 bready = 1'b0;
   endtask

   task automatic axil_read(input logic [4:0] addr, output logic [DATA_W-1:0] data,
                            output logic [1:0] resp);
      araddr  = addr;
      arvalid = 1'b1;
      rready  = 1'b1;
      @(negedge clk);
      while (!arready) @(negedge clk);
      @(posedge clk);
      #1 arvalid = 1'b0;
      @(negedge clk);
      while (!rvalid) @(negedge clk);
      data = rdata;
      resp = rresp;
      @(posedge clk);
      #1 rready = 1'b0;
   endtask

   task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
      assert (got == exp) else begin
         errors++;
         $display("mismatch %s %s: expected resp %0d, actual %0d", test_name, what, exp, got);
      end
   endtask

   task automatic issue_job(input div_op_t op, input logic [DATA_W-1:0] a,
                            input logic [DATA_W-1:0] b, output logic [1:0] cmd_resp);
      logic [1:0] resp;
      axil_write(REG_DIVIDEND, a, resp);
      check_resp(resp, OKAY, "dividend write");
      axil_write(REG_DIVISOR, b, resp);
      check_resp(resp, OKAY, "divisor write");
      axil_write(REG_CMD, {30'd0, op}, cmd_resp);
      if (cmd_resp == OKAY) begin
         exp_q.push_back(ref_div(op, a, b));
         outstanding++;
      end
   endtask

   task automatic read_result();
      logic [DATA_W-1:0] data;
      logic [1:0]        resp;
      axil_read(REG_RESULT, data, resp);
      check_resp(resp, OKAY, "result read");
      got_q.push_back(data);
      got_name_q.push_back(test_name);
      outstanding--;
   endtask

   task automatic drain_all();
      logic [DATA_W-1:0] st;
      logic [1:0]        resp;
      while (outstanding > 0) begin
         axil_read(REG_STATUS, st, resp);
         if (st[0])
            read_result();
      end
   endtask

   task automatic run_job(input div_op_t op, input logic [DATA_W-1:0] a,
                          input logic [DATA_W-1:0] b);
      logic [1:0] resp;
      issue_job(op, a, b, resp);
      check_resp(resp, OKAY, "command write");
      drain_all();
   endtask

   task automatic signed_test();
      logic [DATA_W-1:0] sa[2];
      logic [DATA_W-1:0] sb[2];
      test_name = "signed";
      sa = '{32'd100, -32'd100};
      sb = '{32'd7, -32'd7};
      foreach (sa[i])
         foreach (sb[j]) begin
            run_job(DIV, sa[i], sb[j]);
            run_job(REM, sa[i], sb[j]);
         end
      run_job(DIV, 32'h8000_0000, 32'hffff_ffff);
      run_job(REM, 32'h8000_0000, 32'hffff_ffff);
   endtask

   task automatic backpressure_test();
      logic [DATA_W-1:0] st;
      logic [1:0]        resp;
      logic              full_seen;
      test_name = "backpressure";
      full_seen = 1'b0;
      axil_write(REG_DIVIDEND, -32'd100, resp);
      axil_write(REG_DIVISOR, 32'd7, resp);
      for (int i = 0; i < 9; i++) begin
         axil_write(REG_CMD, i % 4, resp);
         if (resp == OKAY) begin
            exp_q.push_back(ref_div(div_op_t'(i % 4), -32'd100, 32'd7));
            outstanding++;
         end
         axil_read(REG_STATUS, st, resp);
         full_seen |= st[1];
      end
      assert (full_seen) else begin
         errors++;
         $display("%s: command FIFO full flag was never set", test_name);
      end
      drain_all();
   endtask

   task automatic error_test();
      logic [DATA_W-1:0] data;
      logic [1:0]        resp;
      test_name = "errors";
      axil_read(REG_STATUS, data, resp);
      assert (!data[0]) else begin
         errors++;
         $display("%s: result flagged available with nothing queued", test_name);
      end
      axil_read(REG_RESULT, data, resp);
      check_resp(resp, SLVERR, "empty result read");
      assert (data == '0) else begin
         errors++;
         $display("mismatch %s: expected %h, actual %h", test_name, 32'h0, data);
      end
      axil_write(5'h14, 32'h1, resp);
      check_resp(resp, SLVERR, "unknown address write");
      axil_read(5'h18, data, resp);
      check_resp(resp, SLVERR, "unknown address read");
   endtask

   task automatic random_test();
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] b;
      logic [DATA_W-1:0] r;
      logic [DATA_W-1:0] st;
      logic [1:0]        resp;
      test_name = "random";
      for (int n = 0; n < 200; n++) begin
         r = $random(seed);
         a = $random(seed);
         b = $random(seed);
         if (b[31:30] == 2'b00)
            b = b & 32'h0f;  // Small divisors, zero too.
         axil_read(REG_STATUS, st, resp);
         while (st[1]) begin
            if (st[0])
               read_result();
            axil_read(REG_STATUS, st, resp);
         end
         issue_job(div_op_t'(r[1:0]), a, b, resp);
         check_resp(resp, OKAY, "command write");
         axil_read(REG_STATUS, st, resp);
         if (st[0])
            read_result();
      end
      drain_all();
   endtask

   always @(posedge clk) begin
      logic [DATA_W-1:0] got;
      logic [DATA_W-1:0] exp;
      string             name;
      while (got_q.size() > 0) begin
         got  = got_q.pop_front();
         name = got_name_q.pop_front();
         assert (exp_q.size() > 0) else begin
            errors++;
            $display("%s: result read with no job outstanding", name);
         end
         if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            assert (got == exp) else begin
               errors++;
               $display("mismatch %s: expected %h, actual %h", name, exp, got);
            end
         end
      end
   end

   initial begin
      seed    = 32'h549b_0808;
      resetn  = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = 4'hf;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      repeat (5) @(posedge clk);
      #1 resetn = 1'b1;

      test_name = "unsigned";
      run_job(DIVU, 32'd100, 32'd7);
      run_job(REMU, 32'd100, 32'd7);
      run_job(DIVU, 32'd5, 32'd9);  // Dividend below divisor.
      run_job(REMU, 32'd5, 32'd9);
      run_job(DIVU, 32'hdead_beef, 32'd1);
      run_job(REMU, 32'hdead_beef, 32'd1);
      run_job(DIVU, 32'hffff_ffff, 32'h10);
      run_job(REMU, 32'hffff_ffff, 32'h10);
      signed_test();

      test_name = "div_by_zero";
      run_job(DIVU, -32'd12345, 32'd0);
      run_job(DIV, -32'd12345, 32'd0);
      run_job(REMU, -32'd12345, 32'd0);
      run_job(REM, -32'd12345, 32'd0);

      backpressure_test();
      error_test();
      random_test();

      repeat (2) @(posedge clk);
      assert (exp_q.size() == 0) else begin
         errors++;
         $display("%0d expected results were never read back", exp_q.size());
      end
      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout after %0d cycles, the DUT stopped responding", TIMEOUT_CYCLES);
      $display("Errors: %0d", errors);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- build.f
div_pkg.sv
div_fifo.sv
div_axil_regs.sv
div_seq_core.sv
div_unit_top.sv
tb_div_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f build.f \
   --top-module tb_div_unit -o sim_div_unit
./obj_dir/sim_div_unit | tee sim.log
if grep -q "Simulation completed successfully" sim.log; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1
